// ==== verilog/lincrypt_pkg.sv ====
package lincrypt_pkg;

    // block geometry
    localparam int BLOCK_W  = 32;
    localparam int HALF_W   = BLOCK_W / 2;       // feistel half
    localparam int REGION_W = 24;                // fixed high plaintext bits
    localparam int LOW_W    = BLOCK_W - REGION_W; // swept low bits, 256 plaintexts
    localparam int CNT_W    = 9;                 // holds a full region count of 256
    localparam int ROUNDS   = 4;                 // also the pipeline depth

    // single 4-bit sbox, applied to every nibble of a half
    localparam logic [3:0] SBOX [16] = '{
        4'hC, 4'h5, 4'h6, 4'hB, 4'h9, 4'h0, 4'hA, 4'hD,
        4'h3, 4'hE, 4'hF, 4'h8, 4'h4, 4'h7, 4'h1, 4'h2
    };

    // round keys, index = round number
    localparam logic [HALF_W-1:0] ROUND_KEYS [ROUNDS] = '{
        16'h3A94, 16'hC15E, 16'h7D02, 16'hB6E8
    };

    // linear approximation under test
    localparam logic [BLOCK_W-1:0] MASK_IN  = 32'h0004_0083; // plaintext side
    localparam logic [BLOCK_W-1:0] MASK_OUT = 32'h2100_0800; // ciphertext side

    // left is the high half, as in des
    typedef struct packed {
        logic [HALF_W-1:0] left;
        logic [HALF_W-1:0] right;
    } halves_t;

    // one block seen as a flat word (masks, ports) or as two halves (rounds)
    typedef union packed {
        logic [BLOCK_W-1:0] word;
        halves_t            halves;
    } block_u;

    // fsm to datapath
    typedef struct packed {
        logic start_msg;  // load region, restart the plaintext sweep
        logic pause;      // global stall, every stateful block holds
    } sweep_ctrl_t;

    // datapath back to fsm
    typedef struct packed {
        logic gen_done;   // last plaintext issued this cycle
        logic out_valid;  // pipeline output holds a ciphertext
    } pipe_stat_t;

endpackage

// ==== verilog/region_counter.sv ====
`timescale 1ns/1ps

module region_counter (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             restart_block,
    input  lincrypt_pkg::sweep_ctrl_t        ctrl,
    input  logic [lincrypt_pkg::REGION_W-1:0] region_select,
    output lincrypt_pkg::block_u             msg,
    output logic                             msg_valid,
    output logic                             gen_done
);
    import lincrypt_pkg::*;

    logic [REGION_W-1:0] region_q;  // high bits, fixed for the whole sweep
    logic [LOW_W-1:0]    step_q;    // low bits, walks 0 .. 255
    logic                valid_q;
    logic                last_step;

    assign last_step = (step_q == {LOW_W{1'b1}});

    // high plaintext bits captured on start
    always_ff @(posedge clk) begin
        if (ctrl.start_msg) begin
            region_q <= region_select;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || restart_block) begin
            valid_q <= 1'b0;
            step_q  <= '0;
        end else if (ctrl.start_msg) begin
            valid_q <= 1'b1;                // region:0 valid from next cycle
            step_q  <= '0;
        end else if (!ctrl.pause && valid_q) begin
            step_q <= step_q + 1'b1;        // next plaintext on every advancing cycle
            if (last_step) begin
                valid_q <= 1'b0;            // region:255 just went out
            end
        end
    end

    // the plaintext word is simply region concatenated with the step
    assign msg.word  = {region_q, step_q};
    assign msg_valid = valid_q;

    // pulse only in the cycle the last plaintext is accepted downstream
    assign gen_done = valid_q && !ctrl.pause && last_step;

endmodule

// ==== verilog/feistel_pipe.sv ====
`timescale 1ns/1ps

module feistel_pipe (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 restart_block,
    input  logic                 pause,
    input  lincrypt_pkg::block_u in_blk,
    input  logic                 in_valid,
    output lincrypt_pkg::block_u out_blk,
    output logic                 out_valid
);
    import lincrypt_pkg::*;

    block_u            rnd_in  [ROUNDS];  // round inputs, chained from previous stage
    block_u            rnd_out [ROUNDS];  // combinational round results
    block_u            stage_q [ROUNDS];  // one register per round
    logic [ROUNDS-1:0] valid_q;           // valid bit travels with each stage

    // keyed round function
    // key mix, nibble-wise sbox, then rotate left by 3
    function automatic logic [HALF_W-1:0] round_f(
        input logic [HALF_W-1:0] half,
        input logic [HALF_W-1:0] key
    );
        logic [HALF_W-1:0] mixed;
        logic [HALF_W-1:0] subst;
        mixed = half ^ key;
        for (int n = 0; n < HALF_W / 4; n++) begin
            subst[n*4 +: 4] = SBOX[mixed[n*4 +: 4]];
        end
        return {subst[HALF_W-4:0], subst[HALF_W-1:HALF_W-3]};
    endfunction

    assign rnd_in[0] = in_blk;

    for (genvar r = 0; r < ROUNDS; r++) begin : g_round
        if (r > 0) begin : g_chain
            assign rnd_in[r] = stage_q[r-1];
        end
        // L' = R, R' = L ^ F(R, K)
        assign rnd_out[r].halves = '{
            left:  rnd_in[r].halves.right,
            right: rnd_in[r].halves.left ^ round_f(rnd_in[r].halves.right, ROUND_KEYS[r])
        };
    end

    // data stages move together whenever the pipeline is not paused
    always_ff @(posedge clk) begin
        if (!pause) begin
            for (int r = 0; r < ROUNDS; r++) begin
                stage_q[r] <= rnd_out[r];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || restart_block) begin
            valid_q <= '0;
        end else if (!pause) begin
            valid_q <= {valid_q[ROUNDS-2:0], in_valid}; // bubbles move through too
        end
    end

    // last round feeds the output directly with no final swap
    assign out_blk   = stage_q[ROUNDS-1];
    assign out_valid = valid_q[ROUNDS-1];

endmodule

// ==== verilog/bias_accumulator.sv ====
`timescale 1ns/1ps

module bias_accumulator (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          restart_block,
    input  logic                          pause,
    input  lincrypt_pkg::block_u          msg,
    input  logic                          msg_valid,
    input  lincrypt_pkg::block_u          ct,
    input  logic                          ct_valid,
    output logic [lincrypt_pkg::CNT_W-1:0] counter
);
    import lincrypt_pkg::*;

    logic [ROUNDS-1:0] par_q;    // input parity, delayed like the cipher stages
    logic [CNT_W-1:0]  cnt_q;
    logic              in_par;
    logic              out_par;
    logic              hit;      // approximation fails for this pair
    logic              count_en; // ciphertext leaves the pipeline now

    assign in_par  = ^(msg.word & MASK_IN);
    assign out_par = ^(ct.word & MASK_OUT);

    // same shift condition as the feistel stages so the bits stay aligned
    // with their ciphertexts, bubbles carry zero
    always_ff @(posedge clk) begin
        if (!pause) begin
            par_q <= {par_q[ROUNDS-2:0], in_par & msg_valid};
        end
    end

    assign count_en = ct_valid && !pause;
    assign hit      = par_q[ROUNDS-1] ^ out_par;

    always_ff @(posedge clk) begin
        if (!rst_n || restart_block) begin
            cnt_q <= '0;
        end else if (count_en && hit) begin
            cnt_q <= cnt_q + 1'b1;  // 256 max, fits CNT_W
        end
    end

    assign counter = cnt_q;

endmodule

// ==== verilog/sweep_fsm.sv ====
`timescale 1ns/1ps

module sweep_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      restart_block,
    input  logic                      start,
    input  logic                      test_enabled,
    input  logic                      test_advance,
    input  lincrypt_pkg::pipe_stat_t  stat,
    output lincrypt_pkg::sweep_ctrl_t ctrl,
    output logic                      done,
    output logic                      test_data_valid
);
    import lincrypt_pkg::*;

    typedef enum logic [2:0] {
        idle,
        working,    // generator issuing plaintexts
        draining,   // generator finished, pipeline emptying
        finished,
        test_fill,  // run until a ciphertext shows up
        test_hold,  // ciphertext frozen for the host
        test_step   // one advancing cycle
    } state_t;

    state_t state_q;
    state_t state_d;

    always_ff @(posedge clk) begin
        if (!rst_n || restart_block) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle: begin
                if (start) begin
                    state_d = test_enabled ? test_fill : working;
                end
            end
            working:   if (stat.gen_done) state_d = draining;
            draining:  if (!stat.out_valid) state_d = finished;
            finished:  state_d = finished;               // only restart_block leaves
            test_fill: begin
                if (!test_enabled) state_d = idle;
                else if (stat.out_valid) state_d = test_hold;
            end
            test_hold: begin
                if (!test_enabled) state_d = idle;
                else if (test_advance) state_d = test_step;
            end
            test_step: state_d = test_enabled ? test_fill : idle;
            default:   state_d = idle;
        endcase
    end

    // pause is combinational so a fresh test ciphertext freezes in the cycle it appears
    always_comb begin
        ctrl.start_msg = (state_q == idle) && start;
        case (state_q)
            working, draining, test_step: ctrl.pause = 1'b0;
            test_fill:                    ctrl.pause = stat.out_valid;
            default:                      ctrl.pause = 1'b1;  // idle, finished, test_hold
        endcase
    end

    assign done            = (state_q == finished);
    assign test_data_valid = (state_q == test_hold);

endmodule

// ==== verilog/lincrypt_block.sv ====
`timescale 1ns/1ps

module lincrypt_block (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  logic                              restart_block,
    input  logic                              test_enabled,
    input  logic                              test_advance,
    input  logic [lincrypt_pkg::REGION_W-1:0] region_select,
    output logic                              done,
    output logic                              test_data_valid,
    output logic [lincrypt_pkg::CNT_W-1:0]    counter,
    output lincrypt_pkg::block_u              ciphertext_out
);
    import lincrypt_pkg::*;

    sweep_ctrl_t ctrl;
    pipe_stat_t  stat;
    block_u      msg;
    block_u      ct;
    logic        msg_valid;
    logic        gen_done;
    logic        out_valid;
    logic        sweep_clear;  // restart, or a new sweep starting

    // each sweep begins with an empty pipeline and a zero count
    assign sweep_clear = restart_block | ctrl.start_msg;

    assign stat.gen_done  = gen_done;
    assign stat.out_valid = out_valid;

    sweep_fsm u_fsm (
        .clk(clk), .rst_n(rst_n), .restart_block(restart_block),
        .start(start), .test_enabled(test_enabled), .test_advance(test_advance),
        .stat(stat), .ctrl(ctrl), .done(done), .test_data_valid(test_data_valid)
    );

    region_counter u_gen (
        .clk(clk), .rst_n(rst_n), .restart_block(restart_block),
        .ctrl(ctrl), .region_select(region_select),
        .msg(msg), .msg_valid(msg_valid), .gen_done(gen_done)
    );

    feistel_pipe u_pipe (
        .clk(clk), .rst_n(rst_n), .restart_block(sweep_clear), .pause(ctrl.pause),
        .in_blk(msg), .in_valid(msg_valid), .out_blk(ct), .out_valid(out_valid)
    );

    bias_accumulator u_acc (
        .clk(clk), .rst_n(rst_n), .restart_block(sweep_clear), .pause(ctrl.pause),
        .msg(msg), .msg_valid(msg_valid), .ct(ct), .ct_valid(out_valid),
        .counter(counter)
    );

    assign ciphertext_out = ct;  // host checks this in test mode

endmodule

// ==== dv/lincrypt_model.svh ====
`ifndef LINCRYPT_MODEL_SVH
`define LINCRYPT_MODEL_SVH

// reference cipher built straight from the round description
function automatic logic [HALF_W-1:0] round_func(
    input logic [HALF_W-1:0] r,
    input logic [HALF_W-1:0] k
);
    logic [HALF_W-1:0] x;
    logic [HALF_W-1:0] s;
    x = r ^ k;                                  // key mix
    for (int i = 0; i < HALF_W / 4; i++) begin
        s[4*i +: 4] = SBOX[x[4*i +: 4]];       // nibble substitution
    end
    return (s << 3) | (s >> (HALF_W - 3));     // rotate left by 3
endfunction

function automatic logic [BLOCK_W-1:0] encrypt_block(input logic [BLOCK_W-1:0] pt);
    logic [HALF_W-1:0] l;
    logic [HALF_W-1:0] r;
    logic [HALF_W-1:0] t;
    l = pt[BLOCK_W-1:HALF_W];
    r = pt[HALF_W-1:0];
    for (int i = 0; i < ROUNDS; i++) begin
        t = r;
        r = l ^ round_func(r, ROUND_KEYS[i]);
        l = t;
    end
    return {l, r};                              // no final swap
endfunction

// bit by bit parity of the masked word
function automatic logic masked_parity(input logic [BLOCK_W-1:0] w, input logic [BLOCK_W-1:0] m);
    logic p;
    p = 1'b0;
    for (int i = 0; i < BLOCK_W; i++) begin
        p = p ^ (w[i] & m[i]);
    end
    return p;
endfunction

// number of plaintexts in the region where the two parities differ
function automatic int region_bias_count(input logic [REGION_W-1:0] region);
    logic [BLOCK_W-1:0] pt;
    logic [BLOCK_W-1:0] ct;
    int n;
    n = 0;
    for (int low = 0; low < (1 << LOW_W); low++) begin
        pt = {region, low[LOW_W-1:0]};
        ct = encrypt_block(pt);
        if (masked_parity(pt, MASK_IN) != masked_parity(ct, MASK_OUT)) begin
            n++;
        end
    end
    return n;
endfunction

`endif

// ==== dv/lincrypt_tb.sv ====
`timescale 1ns/1ps

module lincrypt_tb;
    import lincrypt_pkg::*;

    `include "lincrypt_model.svh"

    localparam int SWEEP_LIMIT = 400;   // 256 issues plus drain, with margin
    localparam int STEP_LIMIT  = 40;
    localparam int TEST_STEPS  = 12;    // ciphertexts checked in test mode
    localparam int DONE_HOLD   = 4;     // cycles done is watched before a restart

    logic                clk;
    logic                rst_n;
    logic                start;
    logic                restart_block;
    logic                test_enabled;
    logic                test_advance;
    logic [REGION_W-1:0] region_select;
    logic                done;
    logic                test_data_valid;
    logic [CNT_W-1:0]    counter;
    block_u              ciphertext_out;

    integer seed = 32'h133e;
    int     value_errors = 0;
    int     timeout_errors = 0;

    lincrypt_block u_dut (
        .clk(clk), .rst_n(rst_n), .start(start), .restart_block(restart_block),
        .test_enabled(test_enabled), .test_advance(test_advance),
        .region_select(region_select), .done(done), .test_data_valid(test_data_valid),
        .counter(counter), .ciphertext_out(ciphertext_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // held test ciphertext must not move
    assert property (@(posedge clk) disable iff (!rst_n)
        test_data_valid |=> $stable(ciphertext_out))
    else begin
        value_errors++;
        $display("ERR ciphertext_out changed while held, now %h", ciphertext_out.word);
    end

    // done is sticky until restart_block
    assert property (@(posedge clk) disable iff (!rst_n)
        done && !restart_block |=> done)
    else begin
        value_errors++;
        $display("ERR done got %h expected 1 with restart_block low", done);
    end

    task automatic expect_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [REGION_W-1:0] next_region();
        logic [31:0] rnd;
        rnd = $random(seed);
        return rnd[REGION_W-1:0];
    endfunction

    task automatic wait_done(input int limit);
        int n = 0;
        while (!done && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            timeout_errors++;
            $display("timed out after %0d cycles waiting for done", limit);
        end
    endtask

    task automatic wait_test_valid(input int limit);
        int n = 0;
        while (!test_data_valid && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!test_data_valid) begin
            timeout_errors++;
            $display("timed out after %0d cycles waiting for test_data_valid", limit);
        end
    endtask

    task automatic pulse_start(input logic [REGION_W-1:0] region);
        region_select = region;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic pulse_restart();
        restart_block = 1'b1;
        @(negedge clk);
        restart_block = 1'b0;
    endtask

    // full region sweep, count checked against the model
    task automatic run_sweep(input logic [REGION_W-1:0] region);
        $display("sweep of region %h", region);
        pulse_start(region);
        wait_done(SWEEP_LIMIT);
        repeat (DONE_HOLD) @(negedge clk);  // done has to stay up meanwhile
        expect_equal("counter", counter, region_bias_count(region));
    endtask

    // global guard on top of the per-wait limits
    initial begin
        repeat (20000) @(posedge clk);
        $display("watchdog expired before the test sequence ended");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic [REGION_W-1:0] region;
        logic [31:0]         rnd;
        rst_n         = 1'b0;
        start         = 1'b0;
        restart_block = 1'b0;
        test_enabled  = 1'b0;
        test_advance  = 1'b0;
        region_select = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        expect_equal("done", done, 0);
        expect_equal("test_data_valid", test_data_valid, 0);
        expect_equal("counter", counter, 0);

        run_sweep(next_region());

        pulse_restart();                    // clears count and done
        expect_equal("done", done, 0);
        expect_equal("counter", counter, 0);
        run_sweep(next_region());

        // single step mode, ciphertexts in plaintext order
        pulse_restart();
        region = next_region();
        test_enabled = 1'b1;
        pulse_start(region);
        for (int k = 0; k < TEST_STEPS; k++) begin
            wait_test_valid(STEP_LIMIT);
            expect_equal("ciphertext_out", ciphertext_out.word,
                         encrypt_block({region, k[LOW_W-1:0]}));
            rnd = $random(seed);
            repeat (rnd[2:0]) @(negedge clk);   // host think time
            test_advance = 1'b1;
            @(negedge clk);
            test_advance = 1'b0;
        end
        wait_test_valid(STEP_LIMIT);

        test_enabled = 1'b0;                // back to idle
        @(negedge clk);
        expect_equal("test_data_valid", test_data_valid, 0);
        expect_equal("done", done, 0);
        run_sweep(next_region());

        $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+dv
verilog/lincrypt_pkg.sv
verilog/region_counter.sv
verilog/feistel_pipe.sv
verilog/bias_accumulator.sv
verilog/sweep_fsm.sv
verilog/lincrypt_block.sv
dv/lincrypt_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module lincrypt_tb \
    -f all.f --Mdir obj_dir -o lincrypt_sim
./obj_dir/lincrypt_sim | tee sim.log
if grep -q "Simulation PASSED" sim.log; then
    exit 0
fi
echo "run.sh: testbench reported failure"
exit 1
